// ==== rtl/dcache_pkg.sv ====
// data cache shared definitions
// bus widths, word types, transfer size and byte-lane decode

package dcache_pkg;

  // ----------------------------------------
  // widths
  // ----------------------------------------
  localparam int ADDR_W  = 32;  // physical byte address
  localparam int DATA_W  = 32;  // cpu word
  localparam int BYTES_W = DATA_W / 8;  // byte lanes per word

  typedef logic [ADDR_W-1:0]  addr_t;
  typedef logic [DATA_W-1:0]  word_t;
  typedef logic [BYTES_W-1:0] be_t;

  // transfer size as driven by the cpu
  typedef enum logic [1:0] {
    SZ_BYTE = 2'b00,
    SZ_HALF = 2'b01,
    SZ_WORD = 2'b10
  } size_e;

  // ----------------------------------------
  // size + low address bits -> lane enables
  // ----------------------------------------
  function automatic be_t size_to_be(input size_e size,
                                     input logic [$clog2(BYTES_W)-1:0] lsb);
    be_t be;
    case (size)
      SZ_BYTE: be = be_t'(1) << lsb;  // single lane
      SZ_HALF: be = be_t'(3) << {lsb[$clog2(BYTES_W)-1:1], 1'b0};  // even pair
      SZ_WORD: be = '1;
      default: be = '1;  // reserved code, treat as word
    endcase
    return be;
  endfunction

endpackage

// ==== rtl/dcache_ram.sv ====
// single-port synchronous RAM, write-first
// payload type set per instance, holds tags or whole lines

module dcache_ram #(
  parameter int  DEPTH     = 16,
  parameter type payload_t = logic [31:0]
) (
  input  logic                     clk_i,
  input  logic [$clog2(DEPTH)-1:0] addr_i,
  input  logic                     we_i,
  input  payload_t                 wdata_i,
  output payload_t                 rdata_o
);

  payload_t mem_q [DEPTH];  // storage array

  // read port registered, new data wins on a write
  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem_q[addr_i] <= wdata_i;
      rdata_o       <= wdata_i;  // write-first
    end else begin
      rdata_o <= mem_q[addr_i];
    end
  end

  // a write to an unknown address would corrupt an unknown entry
  a_addr_known: assert property (
    @(posedge clk_i) we_i |-> !$isunknown(addr_i)
  );

endmodule

// ==== rtl/dcache_lookup.sv ====
// tag store with valid and dirty flags
// compares the stored tag against the registered request tag

module dcache_lookup import dcache_pkg::*; #(
  parameter  int SETS       = 16,
  parameter  int LINE_WORDS = 4,
  localparam int IDX_W      = $clog2(SETS),
  localparam int TAG_W      = ADDR_W - IDX_W - $clog2(LINE_WORDS) - $clog2(BYTES_W)
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic [IDX_W-1:0] idx_i,
  input  logic [TAG_W-1:0] tag_i,
  input  logic             tag_we_i,
  input  logic             set_dirty_i,
  input  logic             clr_dirty_i,
  output logic             hit_o,
  output logic             victim_dirty_o,
  output logic [TAG_W-1:0] victim_tag_o
);

  typedef logic [TAG_W-1:0] tag_t;

  logic [IDX_W-1:0] idx_q;    // index of the current ram read
  tag_t             tag_q;    // request tag, same cycle as idx_q
  tag_t             ram_tag;
  logic [SETS-1:0]  valid_q;
  logic [SETS-1:0]  dirty_q;

  dcache_ram #(
    .DEPTH     (SETS),
    .payload_t (tag_t)
  ) u_tag_ram (
    .clk_i   (clk_i),
    .addr_i  (idx_i),
    .we_i    (tag_we_i),
    .wdata_i (tag_i),
    .rdata_o (ram_tag)
  );

  always_ff @(posedge clk_i) begin
    idx_q <= idx_i;
    tag_q <= tag_i;
  end

  // ----------------------------------------
  // flags, kept in flops so reset invalidates
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else begin
      if (tag_we_i) begin  // refill, line valid and clean
        valid_q[idx_i] <= 1'b1;
        dirty_q[idx_i] <= 1'b0;
      end
      if (set_dirty_i) dirty_q[idx_i] <= 1'b1;  // store hit
      if (clr_dirty_i) dirty_q[idx_i] <= 1'b0;  // after write-back
    end
  end

  assign hit_o          = valid_q[idx_q] && (ram_tag == tag_q);
  assign victim_dirty_o = valid_q[idx_q] && dirty_q[idx_q];
  assign victim_tag_o   = ram_tag;

  a_dirty_excl: assert property (
    @(posedge clk_i) disable iff (!rst_ni) !(set_dirty_i && clr_dirty_i)
  );

endmodule

// ==== rtl/dcache_ctrl.sv ====
// cache control FSM
// sequences lookup, write-back, refill and flush, answers the cpu

module dcache_ctrl import dcache_pkg::*; #(
  parameter  int SETS       = 16,
  parameter  int LINE_WORDS = 4,
  localparam int IDX_W      = $clog2(SETS),
  localparam int OFF_W      = $clog2(LINE_WORDS),
  localparam int LSB_W      = $clog2(BYTES_W),
  localparam int TAG_W      = ADDR_W - IDX_W - OFF_W - LSB_W,
  localparam int LINE_W     = LINE_WORDS * DATA_W
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  // cpu side
  input  logic              req_i,
  input  logic              we_i,
  input  addr_t             adr_i,
  input  size_e             size_i,
  input  word_t             wdata_i,
  output logic              ack_o,
  output word_t             rdata_o,
  input  logic              flush_i,
  output logic              flushrdy_o,
  // tag lookup
  output logic [IDX_W-1:0]  lookup_idx_o,
  output logic [TAG_W-1:0]  new_tag_o,
  output logic              tag_we_o,
  output logic              set_dirty_o,
  output logic              clr_dirty_o,
  input  logic              hit_i,
  input  logic              victim_dirty_i,
  input  logic [TAG_W-1:0]  victim_tag_i,
  // data ram
  output logic [IDX_W-1:0]  dat_idx_o,
  output logic              dat_we_o,
  output logic [LINE_W-1:0] dat_wline_o,
  input  logic [LINE_W-1:0] dat_rline_i,
  // burst engine
  output logic              burst_start_o,
  output logic              burst_we_o,
  output addr_t             burst_adr_o,
  output logic [LINE_W-1:0] evict_line_o,
  input  logic              burst_done_i,
  input  logic [LINE_W-1:0] fill_line_i
);

  typedef enum logic [2:0] {
    S_IDLE, S_LOOKUP, S_WBACK, S_REFILL, S_RECOVER, S_FLUSH
  } state_e;

  state_e           state_q;
  logic [IDX_W-1:0] flush_idx_q;  // flush scan position
  logic             scan_wait_q;  // lookup outputs not yet for flush_idx_q
  logic             scanning;
  logic [IDX_W-1:0] req_idx;
  logic [OFF_W-1:0] req_off;
  be_t              be;
  word_t            cur_word, merged_word;
  logic             hit_now, miss_now, wb_done, refill_done, scan_dirty;

  // ----------------------------------------
  // address split and store merge
  // ----------------------------------------
  assign req_idx   = adr_i[OFF_W+LSB_W +: IDX_W];
  assign req_off   = adr_i[LSB_W +: OFF_W];
  assign new_tag_o = adr_i[ADDR_W-1 -: TAG_W];
  assign be        = size_to_be(size_i, adr_i[LSB_W-1:0]);
  assign cur_word  = dat_rline_i[req_off*DATA_W +: DATA_W];
  assign scanning  = !flushrdy_o;  // low for the whole flush

  always_comb begin
    merged_word = cur_word;
    for (int b = 0; b < BYTES_W; b++) begin
      if (be[b]) merged_word[b*8 +: 8] = wdata_i[b*8 +: 8];  // lane-aligned data
    end
  end

  assign lookup_idx_o = scanning ? flush_idx_q : req_idx;
  assign dat_idx_o    = lookup_idx_o;  // tag and data rams read together

  assign hit_now     = (state_q == S_LOOKUP) && hit_i;
  assign miss_now    = (state_q == S_LOOKUP) && !hit_i;
  assign wb_done     = (state_q == S_WBACK) && burst_done_i;
  assign refill_done = (state_q == S_REFILL) && burst_done_i;
  assign scan_dirty  = (state_q == S_FLUSH) && !scan_wait_q && victim_dirty_i;

  assign dat_we_o    = (hit_now && we_i) || refill_done;
  assign tag_we_o    = refill_done;
  assign set_dirty_o = hit_now && we_i;
  assign clr_dirty_o = wb_done;

  always_comb begin
    if (state_q == S_REFILL) begin
      dat_wline_o = fill_line_i;
    end else begin
      dat_wline_o = dat_rline_i;
      dat_wline_o[req_off*DATA_W +: DATA_W] = merged_word;
    end
  end

  // burst requests, one-cycle pulse
  assign burst_start_o = miss_now || (wb_done && !scanning) || scan_dirty;
  assign burst_we_o    = scan_dirty || (miss_now && victim_dirty_i);
  assign burst_adr_o   = burst_we_o ?
                         {victim_tag_i, lookup_idx_o, {(OFF_W+LSB_W){1'b0}}} :
                         {new_tag_o, req_idx, {(OFF_W+LSB_W){1'b0}}};
  assign evict_line_o  = dat_rline_i;

  // ----------------------------------------
  // state machine
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= S_IDLE;
      ack_o       <= 1'b0;
      flushrdy_o  <= 1'b1;
      flush_idx_q <= '0;
      scan_wait_q <= 1'b0;
    end else begin
      ack_o <= 1'b0;  // single-cycle ack
      case (state_q)
        S_IDLE: begin
          if (flush_i) begin
            flushrdy_o  <= 1'b0;
            flush_idx_q <= '0;
            scan_wait_q <= 1'b1;
            state_q     <= S_FLUSH;
          end else if (req_i && !ack_o) begin  // old req still up in ack cycle
            state_q <= S_LOOKUP;
          end
        end
        S_LOOKUP: begin
          if (hit_i) begin
            ack_o   <= 1'b1;
            state_q <= S_IDLE;
          end else begin
            state_q <= victim_dirty_i ? S_WBACK : S_REFILL;
          end
        end
        S_WBACK: begin
          if (burst_done_i) begin
            scan_wait_q <= scanning;
            state_q     <= scanning ? S_FLUSH : S_REFILL;  // refill already started
          end
        end
        S_REFILL:  if (burst_done_i) state_q <= S_RECOVER;
        S_RECOVER: state_q <= S_LOOKUP;  // re-read tag so the retry hits
        S_FLUSH: begin
          if (scan_wait_q) begin
            scan_wait_q <= 1'b0;
          end else if (victim_dirty_i) begin
            state_q <= S_WBACK;
          end else if (flush_idx_q == IDX_W'(SETS - 1)) begin
            flushrdy_o <= 1'b1;  // last set clean
            state_q    <= S_IDLE;
          end else begin
            flush_idx_q <= flush_idx_q + 1'b1;
            scan_wait_q <= 1'b1;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == S_LOOKUP) rdata_o <= cur_word;
  end

  a_ack_req: assert property (
    @(posedge clk_i) disable iff (!rst_ni) ack_o |-> req_i
  );

endmodule

// ==== rtl/dcache_burst.sv ====
// BIU burst engine
// strobe handshake, then one line shifted out or collected beat by beat

module dcache_burst import dcache_pkg::*; #(
  parameter  int LINE_WORDS = 4,
  localparam int OFF_W      = $clog2(LINE_WORDS),
  localparam int LINE_W     = LINE_WORDS * DATA_W
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  // from the controller
  input  logic              start_i,
  input  logic              we_i,
  input  addr_t             adr_i,
  input  logic [LINE_W-1:0] line_i,
  output logic              done_o,
  output logic [LINE_W-1:0] line_o,
  // BIU
  output logic              biu_stb_o,
  output logic              biu_we_o,
  output addr_t             biu_adr_o,
  output word_t             biu_d_o,
  input  logic              biu_stb_ack_i,
  input  logic              biu_ack_i,
  input  word_t             biu_q_i
);

  typedef enum logic [1:0] {B_IDLE, B_STROBE, B_BEATS} bstate_e;

  bstate_e           state_q;
  logic [OFF_W-1:0]  beat_q;  // beats done so far
  logic [LINE_W-1:0] line_q;  // shift register, word 0 at the bottom
  logic              last_beat;

  assign last_beat = (state_q == B_BEATS) && biu_ack_i &&
                     (beat_q == OFF_W'(LINE_WORDS - 1));

  assign biu_stb_o = (state_q == B_STROBE);
  assign biu_d_o   = line_q[DATA_W-1:0];  // current write word
  assign line_o    = line_q;

  // ----------------------------------------
  // control
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= B_IDLE;
      beat_q  <= '0;
      done_o  <= 1'b0;
    end else begin
      done_o <= last_beat;  // cycle after last beat
      case (state_q)
        B_IDLE:   if (start_i) state_q <= B_STROBE;
        B_STROBE: begin
          if (biu_stb_ack_i) begin
            beat_q  <= '0;
            state_q <= B_BEATS;
          end
        end
        B_BEATS: begin
          if (biu_ack_i) beat_q <= beat_q + 1'b1;
          if (last_beat) state_q <= B_IDLE;
        end
        default: state_q <= B_IDLE;
      endcase
    end
  end

  // line buffer, read words enter at the top
  always_ff @(posedge clk_i) begin
    if (state_q == B_IDLE && start_i) begin
      line_q    <= line_i;
      biu_we_o  <= we_i;
      biu_adr_o <= adr_i;
    end else if (state_q == B_BEATS && biu_ack_i) begin
      line_q <= {biu_q_i, line_q[LINE_W-1:DATA_W]};
    end
  end

  a_stb_stable: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    biu_stb_o && !biu_stb_ack_i |=>
      biu_stb_o && $stable(biu_we_o) && $stable(biu_adr_o) && $stable(biu_d_o)
  );

endmodule

// ==== rtl/dcache_top.sv ====
// write-back direct-mapped data cache
// cpu load/store port in front, burst BIU port behind

module dcache_top import dcache_pkg::*; #(
  parameter int SETS       = 16,
  parameter int LINE_WORDS = 4
) (
  input  logic  clk_i,
  input  logic  rst_ni,
  // cpu
  input  logic  req_i,
  input  logic  we_i,
  input  addr_t adr_i,
  input  size_e size_i,
  input  word_t wdata_i,
  output logic  ack_o,
  output word_t rdata_o,
  input  logic  flush_i,
  output logic  flushrdy_o,
  // BIU
  output logic  biu_stb_o,
  output logic  biu_we_o,
  output addr_t biu_adr_o,
  output word_t biu_d_o,
  input  logic  biu_stb_ack_i,
  input  logic  biu_ack_i,
  input  word_t biu_q_i
);

  localparam int IDX_W  = $clog2(SETS);
  localparam int TAG_W  = ADDR_W - IDX_W - $clog2(LINE_WORDS) - $clog2(BYTES_W);
  localparam int LINE_W = LINE_WORDS * DATA_W;

  typedef logic [LINE_W-1:0] line_t;

  // ----------------------------------------
  // internal links
  // ----------------------------------------
  logic [IDX_W-1:0] lookup_idx, dat_idx;
  logic [TAG_W-1:0] new_tag, victim_tag;
  logic             tag_we, set_dirty, clr_dirty;
  logic             hit, victim_dirty;
  logic             dat_we;
  line_t            dat_wline, dat_rline;
  logic             burst_start, burst_we, burst_done;
  addr_t            burst_adr;
  line_t            evict_line, fill_line;

  dcache_lookup #(
    .SETS       (SETS),
    .LINE_WORDS (LINE_WORDS)
  ) u_lookup (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .idx_i          (lookup_idx),
    .tag_i          (new_tag),
    .tag_we_i       (tag_we),
    .set_dirty_i    (set_dirty),
    .clr_dirty_i    (clr_dirty),
    .hit_o          (hit),
    .victim_dirty_o (victim_dirty),
    .victim_tag_o   (victim_tag)
  );

  dcache_ctrl #(
    .SETS       (SETS),
    .LINE_WORDS (LINE_WORDS)
  ) u_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (req_i),
    .we_i           (we_i),
    .adr_i          (adr_i),
    .size_i         (size_i),
    .wdata_i        (wdata_i),
    .ack_o          (ack_o),
    .rdata_o        (rdata_o),
    .flush_i        (flush_i),
    .flushrdy_o     (flushrdy_o),
    .lookup_idx_o   (lookup_idx),
    .new_tag_o      (new_tag),
    .tag_we_o       (tag_we),
    .set_dirty_o    (set_dirty),
    .clr_dirty_o    (clr_dirty),
    .hit_i          (hit),
    .victim_dirty_i (victim_dirty),
    .victim_tag_i   (victim_tag),
    .dat_idx_o      (dat_idx),
    .dat_we_o       (dat_we),
    .dat_wline_o    (dat_wline),
    .dat_rline_i    (dat_rline),
    .burst_start_o  (burst_start),
    .burst_we_o     (burst_we),
    .burst_adr_o    (burst_adr),
    .evict_line_o   (evict_line),
    .burst_done_i   (burst_done),
    .fill_line_i    (fill_line)
  );

  dcache_burst #(
    .LINE_WORDS (LINE_WORDS)
  ) u_burst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .start_i       (burst_start),
    .we_i          (burst_we),
    .adr_i         (burst_adr),
    .line_i        (evict_line),
    .done_o        (burst_done),
    .line_o        (fill_line),
    .biu_stb_o     (biu_stb_o),
    .biu_we_o      (biu_we_o),
    .biu_adr_o     (biu_adr_o),
    .biu_d_o       (biu_d_o),
    .biu_stb_ack_i (biu_stb_ack_i),
    .biu_ack_i     (biu_ack_i),
    .biu_q_i       (biu_q_i)
  );

  // line store, one whole line per set
  dcache_ram #(
    .DEPTH     (SETS),
    .payload_t (line_t)
  ) u_data_ram (
    .clk_i   (clk_i),
    .addr_i  (dat_idx),
    .we_i    (dat_we),
    .wdata_i (dat_wline),
    .rdata_o (dat_rline)
  );

endmodule

// ==== bench/tb_biu_mem.sv ====
// behavioural burst memory on the BIU port
// random strobe and beat stalls, logs every finished burst

module tb_biu_mem import dcache_pkg::*; #(
  parameter int LINE_WORDS = 4,
  parameter int WORDS      = 128
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic [1:0] stall_i,  // wait cycles before the next handshake
  input  logic       biu_stb_i,
  input  logic       biu_we_i,
  input  addr_t      biu_adr_i,
  input  word_t      biu_d_i,
  output logic       biu_stb_ack_o,
  output logic       biu_ack_o,
  output word_t      biu_q_o
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int WIDX_W = $clog2(WORDS);

  word_t mem [WORDS];

  // burst log, one entry per finished burst
  addr_t rec_adr   [$];
  logic  rec_we    [$];
  logic  rec_ok    [$];  // fields held while waiting, no strobe mid-burst

  logic  busy, seen, ok;
  logic  cur_we, st_we;
  addr_t cur_adr, st_adr;
  word_t st_d;             // first-cycle copy of the strobe fields
  int    cnt;              // stall countdown
  int    issued, taken;    // beats acked / beats consumed by the cache

  function automatic int word_index(input addr_t a);
    return int'(a[WIDX_W+1:2]);
  endfunction

  // pattern over every address bit
  initial begin
    for (int i = 0; i < WORDS; i++) mem[i] = (32'(i) * 32'h9e3779b9) ^ 32'h5a5a0f0f;
  end

  // ----------------------------------------
  // strobe and beat handshakes
  // ----------------------------------------
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      biu_stb_ack_o <= 1'b0;
      biu_ack_o     <= 1'b0;
      biu_q_o       <= '0;
      busy = 1'b0;
      seen = 1'b0;
      ok   = 1'b1;
      cnt  = 0;
    end else begin
      if (biu_ack_o) begin  // beat taken on this edge
        if (cur_we) mem[word_index(cur_adr) + taken] = biu_d_i;
        taken++;
      end
      biu_stb_ack_o <= 1'b0;
      biu_ack_o     <= 1'b0;
      if (busy && taken == LINE_WORDS) begin
        rec_adr.push_back(cur_adr);
        rec_we.push_back(cur_we);
        rec_ok.push_back(ok);
        busy = 1'b0;
      end else if (busy) begin
        if (biu_stb_i && !biu_stb_ack_o) ok = 1'b0;  // new strobe inside burst
        if (issued < LINE_WORDS) begin
          if (cnt == 0) begin
            biu_ack_o <= 1'b1;
            biu_q_o   <= mem[word_index(cur_adr) + issued];
            issued++;
            cnt = int'(stall_i);
          end else begin
            cnt--;
          end
        end
      end else if (biu_stb_i && !biu_stb_ack_o) begin
        if (!seen) begin  // first strobe cycle
          seen   = 1'b1;
          st_adr = biu_adr_i;
          st_we  = biu_we_i;
          st_d   = biu_d_i;
          ok     = 1'b1;
          cnt    = int'(stall_i);
        end else if (biu_adr_i !== st_adr || biu_we_i !== st_we || biu_d_i !== st_d) begin
          ok = 1'b0;  // moved while waiting
        end
        if (cnt == 0) begin
          biu_stb_ack_o <= 1'b1;
          busy    = 1'b1;
          seen    = 1'b0;
          cur_adr = st_adr;
          cur_we  = st_we;
          issued  = 0;
          taken   = 0;
          cnt     = int'(stall_i);
        end else begin
          cnt--;
        end
      end
    end
  end

endmodule

// ==== bench/tb_dcache.sv ====
// testbench for the write-back data cache
// random loads, stores and flushes against a byte model

module tb_dcache import dcache_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int SETS       = 8;  // small, forces conflicts
  localparam int LINE_WORDS = 4;
  localparam int LINE_BYTES = LINE_WORDS * BYTES_W;
  localparam int WIN_BYTES  = 512;
  localparam int WIN_LINES  = WIN_BYTES / LINE_BYTES;
  localparam int N_OPS      = 800;
  localparam int TIMEOUT    = 2000;  // cycles per wait
  localparam logic [31:0] SEED = 32'h0170fa30;

  logic       clk_i = 1'b0;
  logic       rst_ni;
  logic       req, we, ack, flush, flushrdy;
  addr_t      adr;
  size_e      size;
  word_t      wdata, rdata;
  logic       biu_stb, biu_we, biu_stb_ack, biu_ack;
  addr_t      biu_adr;
  word_t      biu_d, biu_q;
  logic [1:0] stall_len = '0;

  // reference state
  logic [7:0]  model [WIN_BYTES];  // coherent memory image
  int          c_line  [SETS];     // line number held per set
  logic        c_valid [SETS];
  logic        c_dirty [SETS];
  int          prev_line = -1;
  logic [31:0] rng_q     = SEED;
  logic [31:0] stall_rng = SEED;

  always #4 clk_i = ~clk_i;

  dcache_top #(
    .SETS       (SETS),
    .LINE_WORDS (LINE_WORDS)
  ) uut (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (req),
    .we_i          (we),
    .adr_i         (adr),
    .size_i        (size),
    .wdata_i       (wdata),
    .ack_o         (ack),
    .rdata_o       (rdata),
    .flush_i       (flush),
    .flushrdy_o    (flushrdy),
    .biu_stb_o     (biu_stb),
    .biu_we_o      (biu_we),
    .biu_adr_o     (biu_adr),
    .biu_d_o       (biu_d),
    .biu_stb_ack_i (biu_stb_ack),
    .biu_ack_i     (biu_ack),
    .biu_q_i       (biu_q)
  );

  tb_biu_mem #(
    .LINE_WORDS (LINE_WORDS),
    .WORDS      (WIN_BYTES / BYTES_W)
  ) u_mem (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .stall_i       (stall_len),
    .biu_stb_i     (biu_stb),
    .biu_we_i      (biu_we),
    .biu_adr_i     (biu_adr),
    .biu_d_i       (biu_d),
    .biu_stb_ack_o (biu_stb_ack),
    .biu_ack_o     (biu_ack),
    .biu_q_o       (biu_q)
  );

  // ----------------------------------------
  // random numbers and helpers
  // ----------------------------------------
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_q = lcg_next(rng_q);
    return rng_q;
  endfunction

  // new stall length every cycle
  always @(posedge clk_i) begin
    #1;
    stall_rng = lcg_next(stall_rng);
    stall_len = stall_rng[31:30];
  end

  function automatic be_t lane_mask(input size_e sz, input addr_t a);
    case (sz)
      SZ_BYTE: return be_t'(4'b0001 << a[1:0]);
      SZ_HALF: return a[1] ? be_t'(4'b1100) : be_t'(4'b0011);
      default: return be_t'(4'b1111);
    endcase
  endfunction

  function automatic word_t model_word(input int a);
    word_t w;
    for (int b = 0; b < BYTES_W; b++) w[b*8 +: 8] = model[a + b];
    return w;
  endfunction

  task automatic abort_run();
    $display("Simulation failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic wait_timeout(input string what);
    $display("timeout after %0d cycles waiting for %s at %0t ns", TIMEOUT, what, $time);
    abort_run();
  endtask

  // ----------------------------------------
  // compare tasks
  // ----------------------------------------
  task automatic check_word(input word_t got, input word_t exp, input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: %s, got %h expected %h", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_addr(input addr_t got, input addr_t exp, input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: %s, got %h expected %h", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: %s, got %b expected %b", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_burst(input int i, input logic exp_we, input int line);
    check_addr(u_mem.rec_adr[i], addr_t'(line * LINE_BYTES), "burst address");
    check_bit(u_mem.rec_we[i], exp_we, "burst direction");
    check_bit(u_mem.rec_ok[i], 1'b1, "strobe held stable and alone");
  endtask

  task automatic check_mem_line(input int line);
    int a;
    for (int w = 0; w < LINE_WORDS; w++) begin
      a = line * LINE_BYTES + w * BYTES_W;
      check_word(u_mem.mem[a / BYTES_W], model_word(a), "memory word after write-back");
    end
  endtask

  task automatic clear_records();
    u_mem.rec_adr.delete();
    u_mem.rec_we.delete();
    u_mem.rec_ok.delete();
  endtask

  // ----------------------------------------
  // cpu access, checked against the model
  // ----------------------------------------
  task automatic cpu_access(input logic wr, input addr_t a, input size_e sz, input word_t wd);
    int    line, set, edges, nrec, wa, victim;
    logic  hit_exp, victim_dirty;
    be_t   m;
    word_t mask;
    line         = int'(a) / LINE_BYTES;
    set          = line % SETS;
    wa           = int'(a) & ~(BYTES_W - 1);
    hit_exp      = c_valid[set] && c_line[set] == line;
    victim_dirty = c_valid[set] && c_dirty[set];
    victim       = c_line[set];
    m            = lane_mask(sz, a);
    for (int b = 0; b < BYTES_W; b++) mask[b*8 +: 8] = {8{m[b]}};
    req   = 1'b1;
    we    = wr;
    adr   = a;
    size  = sz;
    wdata = wd;
    edges = 0;
    do begin
      @(posedge clk_i);
      #1;
      edges++;
      if (edges > TIMEOUT) wait_timeout("ack_o");
    end while (!ack);
    if (!wr) check_word(rdata & mask, model_word(wa) & mask, "read data");
    for (int b = 0; b < BYTES_W; b++) begin
      if (wr && m[b]) model[wa + b] = wd[b*8 +: 8];
    end
    nrec = u_mem.rec_adr.size();
    if (hit_exp) begin  // two edges, bus quiet
      check_word(word_t'(edges), word_t'(2), "hit latency in edges");
      check_word(word_t'(nrec), word_t'(0), "bursts on a hit");
    end else if (victim_dirty) begin
      check_word(word_t'(nrec), word_t'(2), "bursts on a dirty miss");
      check_burst(0, 1'b1, victim);  // write-back first
      check_burst(1, 1'b0, line);
      check_mem_line(victim);
    end else begin
      check_word(word_t'(nrec), word_t'(1), "bursts on a clean miss");
      check_burst(0, 1'b0, line);
    end
    c_dirty[set] = hit_exp ? (c_dirty[set] || wr) : wr;
    c_valid[set] = 1'b1;
    c_line[set]  = line;
    clear_records();
    @(posedge clk_i);  // hold through the ack cycle
    #1;
    req       = 1'b0;
    prev_line = line;
  endtask

  task automatic cache_flush();
    int edges;
    int exp_line [$];
    for (int s = 0; s < SETS; s++) begin
      if (c_valid[s] && c_dirty[s]) exp_line.push_back(c_line[s]);  // set order
    end
    flush = 1'b1;
    @(posedge clk_i);
    #1;
    flush = 1'b0;
    check_bit(flushrdy, 1'b0, "flushrdy_o low after flush pulse");
    edges = 0;
    while (!flushrdy) begin
      @(posedge clk_i);
      #1;
      edges++;
      if (edges > TIMEOUT) wait_timeout("flushrdy_o");
    end
    check_word(word_t'(u_mem.rec_adr.size()), word_t'(exp_line.size()),
               "write bursts in flush");
    for (int k = 0; k < exp_line.size(); k++) check_burst(k, 1'b1, exp_line[k]);
    for (int s = 0; s < SETS; s++) c_dirty[s] = 1'b0;
    clear_records();
    for (int l = 0; l < WIN_LINES; l++) check_mem_line(l);  // whole window
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------
  initial begin
    logic [31:0] r, r2;
    int          line;
    addr_t       a;
    size_e       sz;
    rst_ni = 1'b0;
    req    = 1'b0;
    we     = 1'b0;
    adr    = '0;
    size   = SZ_WORD;
    wdata  = '0;
    flush  = 1'b0;
    for (int s = 0; s < SETS; s++) begin
      c_line[s]  = 0;
      c_valid[s] = 1'b0;
      c_dirty[s] = 1'b0;
    end
    repeat (16) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    for (int i = 0; i < WIN_BYTES; i++) model[i] = u_mem.mem[i / BYTES_W][(i % BYTES_W)*8 +: 8];
    check_bit(ack, 1'b0, "ack_o after reset");
    check_bit(biu_stb, 1'b0, "biu_stb_o after reset");
    check_bit(flushrdy, 1'b1, "flushrdy_o after reset");

    for (int n = 0; n < N_OPS; n++) begin
      r = next_rand();
      if (r[31:27] == 5'd0) begin  // about one in 32
        cache_flush();
        cache_flush();  // nothing dirty left
      end else begin
        if (r[26:25] == 2'd0 && prev_line >= 0) line = prev_line;  // revisit for hits
        else line = int'(r[23:8]) % WIN_LINES;
        r2 = next_rand();
        a  = addr_t'(line * LINE_BYTES) + addr_t'(r2[31:28]);
        sz = size_e'(2'(r2[27:24] % 3));
        if (sz == SZ_HALF) a[0] = 1'b0;
        if (sz == SZ_WORD) a[1:0] = 2'b00;
        cpu_access(r2[20], a, sz, next_rand());
      end
    end
    cache_flush();

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

// ==== vlog.f ====
rtl/dcache_pkg.sv
rtl/dcache_ram.sv
rtl/dcache_lookup.sv
rtl/dcache_ctrl.sv
rtl/dcache_burst.sv
rtl/dcache_top.sv
bench/tb_biu_mem.sv
bench/tb_dcache.sv

// ==== Makefile ====
# Verilator build and run for the data cache testbench

VERILATOR ?= verilator
TOP       ?= tb_dcache
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/100ps -Wno-fatal -j 0

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf $(BUILD_DIR)
